//--- verif/consoleVideo_trace.txt
# Columns: write index x y code, frame, probe x y rgb, pad pressed buttons
# Write x and y count 4-pixel units, rgb and pad values are hex
pad 01 01
pad 90 90
pad 6a 6a
pad ff ff
pad 00 00
write 0 10 5 1
write 2 50 25 2
write 5 51 26 3
write 7 150 100 3
probe 40 20 124
probe 200 100 124
frame
probe 39 20 124
probe 40 20 e22
probe 47 20 e22
probe 48 20 124
probe 47 27 e22
probe 40 28 124
probe 200 100 2c4
probe 650 100 000
probe 204 104 2c4
probe 208 104 36f
probe 207 107 2c4
probe 211 111 36f
probe 211 112 124
probe 600 400 36f
probe 100 500 000
write 0 10 5 0
frame
probe 40 20 124
probe 200 100 2c4
probe 208 104 36f
probe 600 400 36f

//--- consoleVideo.f
verilog/vgaPkg.sv
verilog/padPkg.sv
verilog/padReader.sv
verilog/pixelTiming.sv
verilog/spriteBank.sv
verilog/pixelComposer.sv
verilog/consoleVideo.sv
verif/consoleVideo_chk.sv
verif/consoleVideo_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the console video testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module consoleVideo_tb -f consoleVideo.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VconsoleVideo_tb)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
	echo "Simulation returned status $status"
	exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
	exit 0
fi
exit 1

//--- verif/consoleVideo_tb.sv
// Console video testbench
`timescale 1ns/1ps

module consoleVideo_tb;

	localparam int FRAME_CYCLES = vgaPkg::H_TOTAL * vgaPkg::V_TOTAL * vgaPkg::PIXEL_DIV;
	localparam int TIMEOUT_CYCLES = 3 * FRAME_CYCLES + 1000;
	localparam int CW = vgaPkg::COLOR_W;

	logic clk;
	logic rst;
	logic pin0;
	logic pin1;
	logic pin2;
	logic pin3;
	logic pin5;
	logic pin8;
	logic pin6;
	logic [padPkg::BUTTON_W-1:0] buttons;
	logic spriteWe;
	logic [vgaPkg::SPRITE_INDEX_W-1:0] spriteIndex;
	logic [vgaPkg::SPRITE_X_W-1:0] spriteX;
	logic [vgaPkg::SPRITE_Y_W-1:0] spriteY;
	logic [vgaPkg::SPRITE_CODE_W-1:0] spriteCode;
	logic hSync;
	logic vSync;
	logic frameEnd;
	logic [CW-1:0] red;
	logic [CW-1:0] green;
	logic [CW-1:0] blue;

	// Buttons held on the pad, active high
	logic [padPkg::BUTTON_W-1:0] pressed;
	logic selHigh;
	int cyc;
	int colorErrors;
	int buttonErrors;
	int syncErrors;
	int otherErrors;
	int watchCycles;

	consoleVideo dut (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		watchCycles = 0;
		while (watchCycles < TIMEOUT_CYCLES) begin
			@(posedge clk);
			watchCycles++;
		end
		$display("Run timed out after %0d cycles", watchCycles);
		$display("Simulation failed");
		$finish;
	end

	// Three-button pad, select high gives directions with B and C
	assign selHigh = (pin6 !== 1'b0);
	assign pin0 = ~pressed[padPkg::BTN_UP];
	assign pin1 = ~pressed[padPkg::BTN_DOWN];
	assign pin2 = selHigh ? ~pressed[padPkg::BTN_LEFT] : 1'b0;
	assign pin3 = selHigh ? ~pressed[padPkg::BTN_RIGHT] : 1'b0;
	assign pin5 = selHigh ? ~pressed[padPkg::BTN_B] : ~pressed[padPkg::BTN_A];
	assign pin8 = selHigh ? ~pressed[padPkg::BTN_C] : ~pressed[padPkg::BTN_START];

	task automatic checkColor(input int x, input int y,
		input logic [CW-1:0] gotR, input logic [CW-1:0] gotG, input logic [CW-1:0] gotB,
		input logic [CW-1:0] expR, input logic [CW-1:0] expG, input logic [CW-1:0] expB);
		if ({gotR, gotG, gotB} !== {expR, expG, expB}) begin
			colorErrors++;
			$display("ERR %0t: pixel (%0d,%0d) is %h%h%h, expected %h%h%h", $time, x, y,
				gotR, gotG, gotB, expR, expG, expB);
		end
	endtask

	task automatic checkButtons(input logic [padPkg::BUTTON_W-1:0] got,
		input logic [padPkg::BUTTON_W-1:0] expected);
		if (got !== expected) begin
			buttonErrors++;
			$display("ERR %0t: buttons %h, expected %h", $time, got, expected);
		end
	endtask

	task automatic checkSync(input int x, input int y, input logic gotH, input logic gotV,
		input logic expH, input logic expV);
		if ({gotH, gotV} !== {expH, expV}) begin
			syncErrors++;
			$display("ERR %0t: sync at (%0d,%0d) is h%b v%b, expected h%b v%b", $time, x, y,
				gotH, gotV, expH, expV);
		end
	endtask

	// Every cycle also checks the syncs against the raster position
	task automatic nextCycle();
		int pix;
		int x;
		int y;
		@(posedge clk);
		#1;
		cyc++;
		pix = (cyc / vgaPkg::PIXEL_DIV) % (vgaPkg::H_TOTAL * vgaPkg::V_TOTAL);
		x = pix % vgaPkg::H_TOTAL;
		y = pix / vgaPkg::H_TOTAL;
		checkSync(x, y, hSync, vSync, !(x >= 656 && x < 656 + vgaPkg::H_SYNC),
			!(y == 490 || y == 491));
	endtask

	initial begin : main
		int fd;
		int n;
		int a;
		int b;
		int c;
		int d;
		int w;
		int target;
		int frameIdx;
		logic [8*8-1:0] kind;
		logic [8*160-1:0] lineBuf;
		logic [3*CW-1:0] expColor;

		rst = 1'b1;
		spriteWe = 1'b0;
		spriteIndex = '0;
		spriteX = '0;
		spriteY = '0;
		spriteCode = '0;
		pressed = '0;
		cyc = 0;
		frameIdx = 0;
		colorErrors = 0;
		buttonErrors = 0;
		syncErrors = 0;
		otherErrors = 0;
		repeat (8) @(posedge clk);
		#1;
		checkColor(-1, -1, red, green, blue, '0, '0, '0);
		if (hSync !== 1'b1 || vSync !== 1'b1 || pin6 !== 1'b1 || frameEnd !== 1'b0) begin
			otherErrors++;
			$display("Sync, select or frame strobe not at its reset level at %0t", $time);
		end
		// Cycle 0 of the raster starts here
		rst = 1'b0;

		fd = $fopen("verif/consoleVideo_trace.txt", "r");
		if (fd == 0) begin
			otherErrors++;
			$display("Could not open the trace file");
		end else begin
			while ($fgets(lineBuf, fd) != 0) begin
				n = $sscanf(lineBuf, "%s", kind);
				if (n < 1 || kind == "#") begin
					continue;
				end
				if (kind == "write") begin
					n = $sscanf(lineBuf, "%s %d %d %d %d", kind, a, b, c, d);
					spriteWe = 1'b1;
					spriteIndex = vgaPkg::SPRITE_INDEX_W'(a);
					spriteX = vgaPkg::SPRITE_X_W'(b);
					spriteY = vgaPkg::SPRITE_Y_W'(c);
					spriteCode = vgaPkg::SPRITE_CODE_W'(d);
					nextCycle();
					spriteWe = 1'b0;
				end else if (kind == "frame") begin
					while (frameEnd !== 1'b1) begin
						nextCycle();
					end
					// Strobe sits in the last cycle of pixel (799,524)
					if (cyc != (frameIdx + 1) * FRAME_CYCLES - 1) begin
						otherErrors++;
						$display("Frame end %0d came in cycle %0d instead of cycle %0d",
							frameIdx, cyc, (frameIdx + 1) * FRAME_CYCLES - 1);
					end
					frameIdx++;
					nextCycle();
				end else if (kind == "probe") begin
					n = $sscanf(lineBuf, "%s %d %d %h", kind, a, b, expColor);
					// Third cycle of the pixel, colour settled
					target = vgaPkg::PIXEL_DIV * (frameIdx * vgaPkg::H_TOTAL * vgaPkg::V_TOTAL
						+ b * vgaPkg::H_TOTAL + a) + 2;
					if (target < cyc) begin
						otherErrors++;
						$display("Probe at (%0d,%0d) comes after the raster passed it", a, b);
					end else begin
						while (cyc < target) begin
							nextCycle();
						end
						checkColor(a, b, red, green, blue, expColor[3*CW-1 -: CW],
							expColor[2*CW-1 -: CW], expColor[CW-1:0]);
					end
				end else if (kind == "pad") begin
					n = $sscanf(lineBuf, "%s %h %h", kind, a, b);
					pressed = padPkg::BUTTON_W'(a);
					w = 0;
					while (w < 4 * padPkg::PAD_HALF && buttons !== padPkg::BUTTON_W'(b)) begin
						nextCycle();
						w++;
					end
					checkButtons(buttons, padPkg::BUTTON_W'(b));
				end else begin
					otherErrors++;
					$display("Unknown line kind in the trace file");
				end
			end
			$fclose(fd);
		end

		$display("Errors: colour %0d, buttons %0d, sync %0d, other %0d",
			colorErrors, buttonErrors, syncErrors, otherErrors);
		if (colorErrors + buttonErrors + syncErrors + otherErrors == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- verif/consoleVideo_chk.sv
// Raster and sprite table assertions
`timescale 1ns/1ps

module consoleVideo_chk (
	input logic clk,
	input logic rst,
	input logic pixelTick,
	input logic hSync,
	input logic frameEnd,
	input logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_X_W-1:0] activeX,
	input logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_Y_W-1:0] activeY,
	input logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_CODE_W-1:0] activeCode
);

	localparam int HS_CYCLES = vgaPkg::H_SYNC * vgaPkg::PIXEL_DIV;

	// Length of the current hSync low pulse
	int lowCycles;

	always_ff @(posedge clk) begin
		if (rst || hSync) begin
			lowCycles <= 0;
		end else begin
			lowCycles <= lowCycles + 1;
		end
	end

	frameEndOnTick: assert property (@(posedge clk) disable iff (rst) frameEnd |-> pixelTick)
		else $error("frameEnd outside a pixel tick");
	frameEndSingle: assert property (@(posedge clk) disable iff (rst) frameEnd |=> !frameEnd)
		else $error("frameEnd held longer than one cycle");
	hSyncWidth: assert property (@(posedge clk) disable iff (rst)
		$rose(hSync) |-> lowCycles == HS_CYCLES)
		else $error("hSync low pulse of %0d cycles", lowCycles);
	tableCommit: assert property (@(posedge clk) disable iff (rst)
		!$stable({activeX, activeY, activeCode}) |-> $past(frameEnd))
		else $error("Active sprite table changed outside a commit");

endmodule

bind consoleVideo consoleVideo_chk chk (
	.clk(clk), .rst(rst), .pixelTick(pixelTick), .hSync(hSync), .frameEnd(frameEnd),
	.activeX(activeX), .activeY(activeY), .activeCode(activeCode)
);

//--- verilog/consoleVideo.sv
// Console video and pad block
`timescale 1ns/1ps

module consoleVideo (
	input  logic clk,
	input  logic rst,

	// Genesis pad
	input  logic pin0,
	input  logic pin1,
	input  logic pin2,
	input  logic pin3,
	input  logic pin5,
	input  logic pin8,
	output logic pin6,
	output logic [padPkg::BUTTON_W-1:0] buttons,

	// Sprite writes from the processor
	input  logic spriteWe,
	input  logic [vgaPkg::SPRITE_INDEX_W-1:0] spriteIndex,
	input  logic [vgaPkg::SPRITE_X_W-1:0] spriteX,
	input  logic [vgaPkg::SPRITE_Y_W-1:0] spriteY,
	input  logic [vgaPkg::SPRITE_CODE_W-1:0] spriteCode,

	// VGA
	output logic hSync,
	output logic vSync,
	output logic [vgaPkg::COLOR_W-1:0] red,
	output logic [vgaPkg::COLOR_W-1:0] green,
	output logic [vgaPkg::COLOR_W-1:0] blue,
	output logic frameEnd
);

	logic pixelTick;
	logic [vgaPkg::H_COUNT_W-1:0] hCount;
	logic [vgaPkg::V_COUNT_W-1:0] vCount;
	logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_X_W-1:0] activeX;
	logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_Y_W-1:0] activeY;
	logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_CODE_W-1:0] activeCode;

	padReader pad (
		.clk(clk), .rst(rst),
		.pin0(pin0), .pin1(pin1), .pin2(pin2), .pin3(pin3), .pin5(pin5), .pin8(pin8),
		.pin6(pin6), .buttons(buttons)
	);

	pixelTiming timing (
		.clk(clk), .rst(rst),
		.pixelTick(pixelTick), .hCount(hCount), .vCount(vCount),
		.hSync(hSync), .vSync(vSync), .frameEnd(frameEnd)
	);

	spriteBank bank (
		.clk(clk), .rst(rst),
		.spriteWe(spriteWe), .spriteIndex(spriteIndex),
		.spriteX(spriteX), .spriteY(spriteY), .spriteCode(spriteCode),
		.frameEnd(frameEnd),
		.activeX(activeX), .activeY(activeY), .activeCode(activeCode)
	);

	pixelComposer composer (
		.clk(clk), .rst(rst),
		.hCount(hCount), .vCount(vCount),
		.activeX(activeX), .activeY(activeY), .activeCode(activeCode),
		.red(red), .green(green), .blue(blue)
	);

endmodule

//--- verilog/pixelComposer.sv
// Sprite hit test and colour output
`timescale 1ns/1ps

module pixelComposer (
	input  logic clk,
	input  logic rst,
	input  logic [vgaPkg::H_COUNT_W-1:0] hCount,
	input  logic [vgaPkg::V_COUNT_W-1:0] vCount,
	input  logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_X_W-1:0] activeX,
	input  logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_Y_W-1:0] activeY,
	input  logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_CODE_W-1:0] activeCode,
	output logic [vgaPkg::COLOR_W-1:0] red,
	output logic [vgaPkg::COLOR_W-1:0] green,
	output logic [vgaPkg::COLOR_W-1:0] blue
);

	localparam int XW = vgaPkg::H_COUNT_W + 1;
	localparam int YW = vgaPkg::V_COUNT_W + 1;
	localparam int CODE_W = vgaPkg::SPRITE_CODE_W;
	localparam int RGB_W = 3 * vgaPkg::COLOR_W;

	logic [vgaPkg::SPRITE_COUNT-1:0] hit;
	logic [CODE_W-1:0] slotCode [vgaPkg::SPRITE_COUNT];
	logic [CODE_W-1:0] winCode;
	logic [RGB_W-1:0] nextColor;
	logic [XW-1:0] px;
	logic [YW-1:0] py;

	assign px = XW'(hCount);
	assign py = YW'(vCount);

	for (genvar i = 0; i < vgaPkg::SPRITE_COUNT; i++) begin : gSlot
		logic [XW-1:0] left;
		logic [YW-1:0] top;

		// Positions are stored in 4-pixel units
		assign left = XW'(activeX[i*vgaPkg::SPRITE_X_W +: vgaPkg::SPRITE_X_W]) << 2;
		assign top = YW'(activeY[i*vgaPkg::SPRITE_Y_W +: vgaPkg::SPRITE_Y_W]) << 2;
		assign slotCode[i] = activeCode[i*CODE_W +: CODE_W];
		assign hit[i] = (slotCode[i] != '0)
			&& (px >= left) && (px < left + XW'(vgaPkg::SPRITE_SIZE))
			&& (py >= top) && (py < top + YW'(vgaPkg::SPRITE_SIZE));
	end

	// Walk downwards so the lowest slot ends up on top
	always_comb begin
		winCode = '0;
		for (int i = vgaPkg::SPRITE_COUNT - 1; i >= 0; i--) begin
			if (hit[i]) begin
				winCode = slotCode[i];
			end
		end
	end

	always_comb begin
		if (hCount >= vgaPkg::H_ACTIVE || vCount >= vgaPkg::V_ACTIVE) begin
			nextColor = '0;
		end else if (winCode == '0) begin
			nextColor = vgaPkg::BACKGROUND;
		end else begin
			nextColor = vgaPkg::PALETTE[winCode];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			red <= '0;
			green <= '0;
			blue <= '0;
		end else begin
			red <= nextColor[RGB_W-1 -: vgaPkg::COLOR_W];
			green <= nextColor[2*vgaPkg::COLOR_W-1 -: vgaPkg::COLOR_W];
			blue <= nextColor[vgaPkg::COLOR_W-1:0];
		end
	end

endmodule

//--- verilog/spriteBank.sv
// Double-buffered sprite table
`timescale 1ns/1ps

module spriteBank (
	input  logic clk,
	input  logic rst,
	input  logic spriteWe,
	input  logic [vgaPkg::SPRITE_INDEX_W-1:0] spriteIndex,
	input  logic [vgaPkg::SPRITE_X_W-1:0] spriteX,
	input  logic [vgaPkg::SPRITE_Y_W-1:0] spriteY,
	input  logic [vgaPkg::SPRITE_CODE_W-1:0] spriteCode,
	input  logic frameEnd,
	output logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_X_W-1:0] activeX,
	output logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_Y_W-1:0] activeY,
	output logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_CODE_W-1:0] activeCode
);

	// Pending copy, flat with slot 0 in the low bits
	logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_X_W-1:0] pendX;
	logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_Y_W-1:0] pendY;
	logic [vgaPkg::SPRITE_COUNT*vgaPkg::SPRITE_CODE_W-1:0] pendCode;

	always_ff @(posedge clk) begin
		if (rst) begin
			pendX <= '0;
			pendY <= '0;
			pendCode <= '0;
			activeX <= '0;
			activeY <= '0;
			activeCode <= '0;
		end else begin
			if (frameEnd) begin
				activeX <= pendX;
				activeY <= pendY;
				activeCode <= pendCode;
			end
			// A write in the frameEnd cycle misses the copy above
			if (spriteWe) begin
				pendX[spriteIndex*vgaPkg::SPRITE_X_W +: vgaPkg::SPRITE_X_W] <= spriteX;
				pendY[spriteIndex*vgaPkg::SPRITE_Y_W +: vgaPkg::SPRITE_Y_W] <= spriteY;
				pendCode[spriteIndex*vgaPkg::SPRITE_CODE_W +: vgaPkg::SPRITE_CODE_W] <=
					spriteCode;
			end
		end
	end

endmodule

//--- verilog/pixelTiming.sv
// VGA raster timing
`timescale 1ns/1ps

module pixelTiming (
	input  logic clk,
	input  logic rst,
	output logic pixelTick,
	output logic [vgaPkg::H_COUNT_W-1:0] hCount,
	output logic [vgaPkg::V_COUNT_W-1:0] vCount,
	output logic hSync,
	output logic vSync,
	output logic frameEnd
);

	localparam int DIV_W = $clog2(vgaPkg::PIXEL_DIV);
	localparam int HS_START = vgaPkg::H_ACTIVE + vgaPkg::H_FRONT;
	localparam int HS_END = HS_START + vgaPkg::H_SYNC;
	localparam int VS_START = vgaPkg::V_ACTIVE + vgaPkg::V_FRONT;
	localparam int VS_END = VS_START + vgaPkg::V_SYNC;

	logic [DIV_W-1:0] divCount;
	logic [vgaPkg::H_COUNT_W-1:0] hNext;
	logic [vgaPkg::V_COUNT_W-1:0] vNext;
	logic lastCol;
	logic lastLine;

	// Tick in the last cycle of each pixel period
	assign pixelTick = (divCount == DIV_W'(vgaPkg::PIXEL_DIV - 1));
	assign lastCol = (hCount == vgaPkg::H_COUNT_W'(vgaPkg::H_TOTAL - 1));
	assign lastLine = (vCount == vgaPkg::V_COUNT_W'(vgaPkg::V_TOTAL - 1));

	always_comb begin
		hNext = lastCol ? '0 : hCount + 1'b1;
		vNext = vCount;
		if (lastCol) begin
			vNext = lastLine ? '0 : vCount + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			divCount <= '0;
			hCount <= '0;
			vCount <= '0;
			hSync <= 1'b1;
			vSync <= 1'b1;
			frameEnd <= 1'b0;
		end else begin
			divCount <= pixelTick ? '0 : divCount + 1'b1;
			// Set one cycle early so the strobe lands on the wrapping tick
			frameEnd <= (divCount == DIV_W'(vgaPkg::PIXEL_DIV - 2)) && lastCol && lastLine;
			if (pixelTick) begin
				hCount <= hNext;
				vCount <= vNext;
				// Syncs follow the counters they will show next
				hSync <= !(hNext >= HS_START && hNext < HS_END);
				vSync <= !(vNext >= VS_START && vNext < VS_END);
			end
		end
	end

endmodule

//--- verilog/padReader.sv
// Genesis pad scanner
`timescale 1ns/1ps

module padReader (
	input  logic clk,
	input  logic rst,
	input  logic pin0,
	input  logic pin1,
	input  logic pin2,
	input  logic pin3,
	input  logic pin5,
	input  logic pin8,
	output logic pin6,
	output logic [padPkg::BUTTON_W-1:0] buttons
);

	localparam int PHASE_W = $clog2(padPkg::PAD_HALF);

	logic [PHASE_W-1:0] phaseCount;
	logic phaseEnd;

	// High-phase pins: up, down, left, right, B, C (active low)
	logic [5:0] hiPins;

	assign phaseEnd = (phaseCount == PHASE_W'(padPkg::PAD_HALF - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			phaseCount <= '0;
			pin6 <= 1'b1;
			buttons <= '0;
		end else begin
			phaseCount <= phaseEnd ? '0 : phaseCount + 1'b1;
			if (phaseEnd) begin
				pin6 <= ~pin6;
				if (pin6) begin
					hiPins <= {pin8, pin5, pin3, pin2, pin1, pin0};
				end else begin
					// Low phase done, publish the whole word at once
					buttons[padPkg::BTN_UP] <= ~hiPins[0];
					buttons[padPkg::BTN_DOWN] <= ~hiPins[1];
					buttons[padPkg::BTN_LEFT] <= ~hiPins[2];
					buttons[padPkg::BTN_RIGHT] <= ~hiPins[3];
					buttons[padPkg::BTN_B] <= ~hiPins[4];
					buttons[padPkg::BTN_C] <= ~hiPins[5];
					// Select low: pin5 is A, pin8 is Start
					buttons[padPkg::BTN_A] <= ~pin5;
					buttons[padPkg::BTN_START] <= ~pin8;
				end
			end
		end
	end

endmodule

//--- verilog/padPkg.sv
// Genesis pad constants
package padPkg;

	// clk cycles per select phase
	localparam int PAD_HALF = 64;

	localparam int BUTTON_W = 8;

	// Bit positions in the button word
	localparam int BTN_UP = 0;
	localparam int BTN_DOWN = 1;
	localparam int BTN_LEFT = 2;
	localparam int BTN_RIGHT = 3;
	localparam int BTN_A = 4;
	localparam int BTN_B = 5;
	localparam int BTN_C = 6;
	localparam int BTN_START = 7;

endpackage

//--- verilog/vgaPkg.sv
// Video timing and sprite constants
package vgaPkg;

	// Horizontal timing in pixels
	localparam int H_ACTIVE = 640;
	localparam int H_FRONT = 16;
	localparam int H_SYNC = 96;
	localparam int H_BACK = 48;
	localparam int H_TOTAL = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;

	// Vertical timing in lines
	localparam int V_ACTIVE = 480;
	localparam int V_FRONT = 10;
	localparam int V_SYNC = 2;
	localparam int V_BACK = 33;
	localparam int V_TOTAL = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;

	// Raster counter widths
	localparam int H_COUNT_W = $clog2(H_TOTAL);
	localparam int V_COUNT_W = $clog2(V_TOTAL);

	// clk cycles per pixel
	localparam int PIXEL_DIV = 4;

	// Sprite table
	localparam int SPRITE_COUNT = 8;
	localparam int SPRITE_INDEX_W = 3;
	localparam int SPRITE_X_W = 8;
	localparam int SPRITE_Y_W = 7;
	localparam int SPRITE_CODE_W = 2;
	localparam int SPRITE_SIZE = 8;

	// Colour
	localparam int COLOR_W = 4;
	localparam logic [3:1][3*COLOR_W-1:0] PALETTE = {12'h36F, 12'h2C4, 12'hE22};
	localparam logic [3*COLOR_W-1:0] BACKGROUND = 12'h124;

endpackage
